// ==== src.f ====
+incdir+include
hw/la_pkg.sv
hw/la_cmd_decode.sv
hw/la_sampler.sv
hw/la_trigger.sv
hw/la_capture_ctrl.sv
hw/la_tx_arbiter.sv
hw/la_core.sv
test/la_core_assertions.sv
test/la_core_tb.sv

// ==== Bender.yml ====
package:
  name: la_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/la_pkg.sv
      - hw/la_cmd_decode.sv
      - hw/la_sampler.sv
      - hw/la_trigger.sv
      - hw/la_capture_ctrl.sv
      - hw/la_tx_arbiter.sv
      - hw/la_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/la_core_assertions.sv
      - test/la_core_tb.sv

// ==== test/la_core_tb.sv ====
/*
 * la_core_tb
 * random capture runs against la_core with a sample memory model,
 * a transmitter with random busy time and a reference model of the
 * readout order. also covers the ID reply, flow control and soft reset
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_core_tb;

  // six runs of about 900 cycles worst case plus short tests, with over 3x margin
  localparam int MAX_CYCLES = 20000;
  localparam int RUNS       = 5;           // plus one more after soft reset

  logic                  clk_i    = 1'b0;
  logic                  reset_i  = 1'b1;
  logic [`LA_WIDTH-1:0]  input_i  = '0;
  la_pkg::la_opcode_e    opc_i    = la_pkg::OPC_RESET;
  logic [`LA_WIDTH-1:0]  cmd_i    = '0;
  logic                  exec_i   = 1'b0;
  logic                  we_o;
  logic [`LA_ADDR_W-1:0] addr_o;
  logic [`LA_WIDTH-1:0]  mem_o;
  logic [`LA_WIDTH-1:0]  mem_i    = '0;
  logic                  tx_rdy_i = 1'b1;
  logic                  tx_stb_o;
  logic [`LA_WIDTH-1:0]  tx_o;
  logic                  tx_xon_o;
  logic                  tx_xoff_o;

  logic [`LA_WIDTH-1:0]  mem [2**`LA_ADDR_W];
  logic [`LA_WIDTH-1:0]  rx_q [$];        // words seen by the transmitter
  int unsigned           cyc_cnt  = 0;
  int unsigned           rdy_wait = 0;

  // current capture setup
  int                    cur_div;
  int                    cur_rcnt;
  int                    cur_dly;
  int                    cur_stg;
  logic [`LA_WIDTH-1:0]  cur_mask;
  logic [`LA_WIDTH-1:0]  cur_val;
  logic [`LA_WIDTH-1:0]  cur_target;      // first match at or past this
  logic [`LA_WIDTH-1:0]  arm_val;         // bus value when armed

  la_core la_core_i (.*);

  always #4 clk_i = ~clk_i;

  // input bus is a cycle counter
  always @(posedge clk_i) begin
    input_i <= input_i + 1'b1;
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYCLES) begin       // run limit
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $fatal(1);
    end
  end

  // stop at the first bound assertion failure
  always @(posedge clk_i) begin
    if (la_core_i.i_assert.fail_cnt != 0) begin
      $display("assertion in la_core failed before %0t ns", $time);
      $display("sim failed");
      $fatal(1);
    end
  end

  // sample memory with one cycle read latency
  always @(posedge clk_i) begin
    if (we_o) begin
      mem[addr_o] <= mem_o;
    end
    mem_i <= mem[addr_o];
  end

  // transmitter stays busy 1..6 cycles after each word
  always @(posedge clk_i) begin
    if (reset_i) begin
      tx_rdy_i <= 1'b1;
      rdy_wait <= 0;
    end else if (tx_stb_o) begin
      check_eq(tx_rdy_i, 1'b1, "strobe while transmitter busy");
      rx_q.push_back(tx_o);
      tx_rdy_i <= 1'b0;
      rdy_wait <= 1 + $urandom % 6;
    end else if (!tx_rdy_i) begin
      if (rdy_wait <= 1) begin
        tx_rdy_i <= 1'b1;
      end
      rdy_wait <= rdy_wait - 1;
    end
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic send_cmd(input la_pkg::la_opcode_e opc, input logic [31:0] word);
    @(posedge clk_i);
    opc_i  <= opc;
    cmd_i  <= word;
    exec_i <= 1'b1;                        // single-cycle exec strobe
    @(posedge clk_i);
    exec_i <= 1'b0;
  endtask

  // stage n opcode is the C0/C1/C2 base plus 4n
  function automatic la_pkg::la_opcode_e stage_opc(input la_pkg::la_opcode_e base, input int stg);
    return la_pkg::la_opcode_e'(8'(base) + 8'(4 * stg));
  endfunction

  // reference readout is newest first with the trigger at index delay_cnt
  function automatic logic [31:0] expected_word(input logic [31:0] trig, input int idx);
    return trig + (cur_dly - idx) * (cur_div + 1);
  endfunction

  task automatic wait_words(input int n);
    while (rx_q.size() < n) begin
      @(posedge clk_i);
    end
  endtask

  task automatic expect_id_reply();
    rx_q.delete();
    send_cmd(la_pkg::OPC_ID, '0);
    wait_words(1);
    repeat (40) @(posedge clk_i);          // room for a stray second word
    check_eq(rx_q.size(), 1, "ID reply word count");
    check_eq(rx_q[0], `LA_ID_WORD, "ID reply word");
  endtask

  task automatic flow_ctrl_pulse(input la_pkg::la_opcode_e opc, input logic [1:0] exp);
    @(posedge clk_i);
    opc_i  <= opc;
    cmd_i  <= '0;
    exec_i <= 1'b1;
    @(posedge clk_i);
    exec_i <= 1'b0;
    check_eq({tx_xon_o, tx_xoff_o}, 2'b00, "flow pulse in the exec cycle");
    @(posedge clk_i);
    check_eq({tx_xon_o, tx_xoff_o}, exp, "flow pulse one cycle after exec");
    @(posedge clk_i);
    check_eq({tx_xon_o, tx_xoff_o}, 2'b00, "flow pulse longer than one cycle");
  endtask

  task automatic setup_capture();
    la_pkg::la_cmd_u w;
    logic [31:0]     r;
    cur_div  = $urandom % 8;
    cur_rcnt = 2 + $urandom % 31;          // 2..32 words
    cur_dly  = $urandom % cur_rcnt;        // trigger word always sent
    cur_stg  = $urandom % `LA_STAGES;
    r        = $urandom;
    cur_mask = {r[31:16], 16'hfff8};       // upper mask bits random as the bus stays below 2^16
    send_cmd(la_pkg::OPC_DIV, 32'(cur_div));
    w.raw           = '0;
    w.cnt.read_cnt  = 16'(cur_rcnt);
    w.cnt.delay_cnt = 16'(cur_dly);
    send_cmd(la_pkg::OPC_CNT, w.raw);
    for (int n = 0; n < `LA_STAGES; n++) begin
      w.raw            = '0;
      w.trig_cfg.start = (n == cur_stg);   // only one stage started
      w.trig_cfg.stage = 2'(n);
      send_cmd(stage_opc(la_pkg::OPC_CFG0, n), w.raw);
    end
    // 8-aligned target well past read_cnt samples after arm
    cur_target = ((input_i + 32'((cur_rcnt + 4) * (cur_div + 1)) + 32'd23) >> 3) << 3;
    cur_val    = cur_target & cur_mask;
    send_cmd(stage_opc(la_pkg::OPC_MASK0, cur_stg), cur_mask);
    send_cmd(stage_opc(la_pkg::OPC_VAL0, cur_stg), cur_val);
    rx_q.delete();
    send_cmd(la_pkg::OPC_ARM, '0);
    arm_val = input_i;
  endtask

  task automatic verify_readout();
    logic [31:0] trig;
    logic [31:0] step;
    wait_words(cur_rcnt);
    repeat (40) @(posedge clk_i);
    check_eq(rx_q.size(), cur_rcnt, "readout word count");
    step = cur_div + 1;
    trig = rx_q[cur_dly];
    check_eq(trig & cur_mask, cur_val, "trigger word breaks the match rule");
    // the first sample inside the 8-word target block is the trigger
    check_eq(trig >= cur_target && trig < cur_target + step, 1, "trigger word not first match");
    check_eq(rx_q[cur_rcnt-1] >= arm_val, 1, "readout reaches back before arm");
    for (int i = 0; i < cur_rcnt; i++) begin
      check_eq(rx_q[i], expected_word(trig, i), "readout word");
      if (i > cur_dly) begin
        check_eq((rx_q[i] & cur_mask) == cur_val, 0, "older word matches the trigger");
      end
    end
  endtask

  task automatic soft_reset_abort();
    setup_capture();
    repeat (10) @(posedge clk_i);          // still filling since the target is far off
    send_cmd(la_pkg::OPC_RESET, '0);
    @(posedge clk_i);
    for (int i = 0; i < 200; i++) begin
      @(posedge clk_i);
      check_eq(we_o, 1'b0, "memory write after soft reset");
      check_eq(tx_stb_o, 1'b0, "transmit after soft reset");
    end
    check_eq(rx_q.size(), 0, "words sent after soft reset");
  endtask

  initial begin
    void'($urandom(32'hb7c3d274));
    for (int a = 0; a < 2**`LA_ADDR_W; a++) begin
      mem[a] = 32'hf00d_0000 + a * 32'h0101;   // stale words never look like samples
    end
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_eq({we_o, tx_stb_o, tx_xon_o, tx_xoff_o}, 4'b0000, "outputs after reset");

    expect_id_reply();
    flow_ctrl_pulse(la_pkg::OPC_XON, 2'b10);
    flow_ctrl_pulse(la_pkg::OPC_XOFF, 2'b01);
    for (int r = 0; r < RUNS; r++) begin
      setup_capture();
      verify_readout();
    end
    soft_reset_abort();
    setup_capture();                       // re-arm after soft reset
    verify_readout();
    expect_id_reply();

    if (la_core_i.i_assert.fail_cnt != 0) begin
      $display("%0d assertion failures in la_core", la_core_i.i_assert.fail_cnt);
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/la_core_assertions.sv ====
/*
 * la_core_assertions
 * transmit handshake, readout and flow-control pulse checks,
 * bound into every la_core instance
 */
`default_nettype none
`timescale 1ns/1ns

module la_core_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic we_i,
  input logic busy_i,                      // capture readout owns the transmitter
  input logic tx_rdy_i,
  input logic tx_stb_i,
  input logic tx_xon_i,
  input logic tx_xoff_i
);

  int unsigned fail_cnt = 0;               // failed assertions so far

  // strobe only toward a ready transmitter
  a_stb_rdy: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_stb_i |-> tx_rdy_i)
    else begin
      fail_cnt++;
      $error("tx strobe while transmitter not ready");
    end

  a_stb_gap: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_stb_i |=> !tx_stb_i)
    else begin
      fail_cnt++;
      $error("tx strobe on two consecutive cycles");
    end

  a_no_we_read: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_i |-> !we_i)
    else begin
      fail_cnt++;
      $error("memory write during readout");
    end

  // flow control words are single-cycle pulses
  a_xon_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_xon_i |=> !tx_xon_i)
    else begin
      fail_cnt++;
      $error("xon pulse longer than one cycle");
    end

  a_xoff_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_xoff_i |=> !tx_xoff_i)
    else begin
      fail_cnt++;
      $error("xoff pulse longer than one cycle");
    end

endmodule

bind la_core la_core_assertions i_assert (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .we_i      (we_o),
  .busy_i    (cap_busy),
  .tx_rdy_i  (tx_rdy_i),
  .tx_stb_i  (tx_stb_o),
  .tx_xon_i  (tx_xon_o),
  .tx_xoff_i (tx_xoff_o)
);

`default_nettype wire

// ==== hw/la_core.sv ====
/*
 * la_core
 * top of the logic-analyzer core: command decode, sampler and
 * trigger, capture controller and transmit arbiter wired to the pins.
 * sample memory and transmitter sit outside
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_core (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [`LA_WIDTH-1:0]  input_i,   // sampled bus
  // command side
  input  la_pkg::la_opcode_e    opc_i,
  input  logic [`LA_WIDTH-1:0]  cmd_i,
  input  logic                  exec_i,
  // sample memory
  output logic                  we_o,
  output logic [`LA_ADDR_W-1:0] addr_o,
  output logic [`LA_WIDTH-1:0]  mem_o,
  input  logic [`LA_WIDTH-1:0]  mem_i,
  // transmitter
  input  logic                  tx_rdy_i,
  output logic                  tx_stb_o,
  output logic [`LA_WIDTH-1:0]  tx_o,
  output logic                  tx_xon_o,
  output logic                  tx_xoff_o
);

  la_pkg::la_ctrl_s   ctrl;
  la_pkg::la_cmd_u    cmd;
  la_pkg::la_sample_s smpl;
  la_pkg::la_tx_s     cap_tx;              // readout word for the arbiter
  logic               cap_busy;
  logic               run;

  assign mem_o     = smpl.data;            // memory writes the strobed sample
  assign tx_xon_o  = ctrl.xon;
  assign tx_xoff_o = ctrl.xoff;

  la_cmd_decode i_decode (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .exec_i  (exec_i),
    .opc_i   (opc_i),
    .cmd_i   (cmd_i),
    .ctrl_o  (ctrl),
    .cmd_o   (cmd)
  );

  la_sampler i_sampler (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl_i  (ctrl),
    .cmd_i   (cmd),
    .data_i  (input_i),
    .smpl_o  (smpl)
  );

  la_trigger i_trigger (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ctrl_i  (ctrl),
    .cmd_i   (cmd),
    .smpl_i  (smpl),
    .run_o   (run)
  );

  la_capture_ctrl i_capture (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .ctrl_i   (ctrl),
    .cmd_i    (cmd),
    .smpl_i   (smpl),
    .run_i    (run),
    .tx_rdy_i (tx_rdy_i),
    .we_o     (we_o),
    .addr_o   (addr_o),
    .mem_i    (mem_i),
    .tx_o     (cap_tx),
    .busy_o   (cap_busy)
  );

  la_tx_arbiter i_tx_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ctrl_i      (ctrl),
    .smpl_tx_i   (cap_tx),
    .smpl_busy_i (cap_busy),
    .tx_rdy_i    (tx_rdy_i),
    .tx_stb_o    (tx_stb_o),
    .tx_o        (tx_o)
  );

endmodule

`default_nettype wire

// ==== hw/la_tx_arbiter.sv ====
/*
 * la_tx_arbiter
 * shares the transmitter between the sample readout and the ID reply.
 * readout owns it while busy, a pending ID word goes out otherwise
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_tx_arbiter (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  la_pkg::la_ctrl_s     ctrl_i,
  input  la_pkg::la_tx_s       smpl_tx_i,  // from capture readout
  input  logic                 smpl_busy_i,
  input  logic                 tx_rdy_i,
  output logic                 tx_stb_o,
  output logic [`LA_WIDTH-1:0] tx_o
);

  logic rst;
  logic id_pend_q;                         // ID asked, not yet sent
  logic last_stb_q;                        // strobe seen last cycle
  logic id_stb;

  assign rst = reset_i | ctrl_i.soft_rst;

  // never two strobes back to back, whichever sender
  assign id_stb = id_pend_q && !smpl_busy_i && tx_rdy_i && !last_stb_q;

  assign tx_stb_o = smpl_busy_i ? smpl_tx_i.stb  : id_stb;
  assign tx_o     = smpl_busy_i ? smpl_tx_i.data : `LA_ID_WORD;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      id_pend_q  <= 1'b0;
      last_stb_q <= 1'b0;
    end else begin
      id_pend_q  <= (id_pend_q & ~id_stb) | ctrl_i.id_req;
      last_stb_q <= tx_stb_o;
    end
  end

endmodule

`default_nettype wire

// ==== hw/la_capture_ctrl.sv ====
/*
 * la_capture_ctrl
 * capture FSM: idle, fill, delay, read.
 * fill writes samples circularly until run, delay writes delay_cnt
 * more, then read sends read_cnt words newest-first, one-cycle
 * memory latency, one word per transmitter ready
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_capture_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  la_pkg::la_ctrl_s      ctrl_i,
  input  la_pkg::la_cmd_u       cmd_i,
  input  la_pkg::la_sample_s    smpl_i,
  input  logic                  run_i,
  input  logic                  tx_rdy_i,
  output logic                  we_o,
  output logic [`LA_ADDR_W-1:0] addr_o,
  input  logic [`LA_WIDTH-1:0]  mem_i,     // data of last cycle's addr
  output la_pkg::la_tx_s        tx_o,
  output logic                  busy_o     // owns the transmitter
);

  typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_DELAY, ST_READ} state_e;

  state_e                state_q;
  logic                  rst;
  logic [15:0]           read_cnt_q;
  logic [15:0]           delay_cnt_q;
  logic [15:0]           dly_q;            // samples still to write
  logic [15:0]           left_q;           // words still to send
  logic [`LA_ADDR_W-1:0] wr_ptr_q;
  logic [`LA_ADDR_W-1:0] rd_addr_q;
  logic                  rd_vld_q;         // mem_i belongs to rd_addr_q
  logic                  in_delay;
  logic [15:0]           rem;
  logic [15:0]           rem_nxt;
  logic                  we;
  logic [`LA_ADDR_W-1:0] wr_nxt;
  logic                  tx_stb;

  assign rst = reset_i | ctrl_i.soft_rst;

  always_comb begin
    // run in fill already counts as delay, trigger sample is delay zero
    in_delay = (state_q == ST_DELAY) || (state_q == ST_FILL && run_i);
    rem      = (state_q == ST_DELAY) ? dly_q : delay_cnt_q;
    we       = smpl_i.stb && ((state_q == ST_FILL && !run_i) ||
                              (in_delay && rem != '0));
    rem_nxt  = rem - {15'd0, we};
    wr_nxt   = wr_ptr_q + `LA_ADDR_W'(we);
    tx_stb   = (state_q == ST_READ) && rd_vld_q && tx_rdy_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      read_cnt_q  <= '0;
      delay_cnt_q <= '0;
    end else if (ctrl_i.set_cnt) begin
      read_cnt_q  <= cmd_i.cnt.read_cnt;
      delay_cnt_q <= cmd_i.cnt.delay_cnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      wr_ptr_q  <= '0;
      rd_addr_q <= '0;
      dly_q     <= '0;
      left_q    <= '0;
      rd_vld_q  <= 1'b0;
    end else begin
      wr_ptr_q <= wr_nxt;
      if (ctrl_i.arm) begin
        state_q  <= ST_FILL;               // arm restarts the capture
        rd_vld_q <= 1'b0;
      end else begin
        case (state_q)
          ST_FILL, ST_DELAY: begin
            if (in_delay) begin
              dly_q <= rem_nxt;
              if (rem_nxt == '0) begin
                // newest word is the one just written
                rd_addr_q <= wr_nxt - 1'b1;
                left_q    <= read_cnt_q;
                rd_vld_q  <= 1'b0;
                state_q   <= (read_cnt_q == '0) ? ST_IDLE : ST_READ;
              end else begin
                state_q <= ST_DELAY;
              end
            end
          end
          ST_READ: begin
            if (tx_stb) begin
              rd_vld_q  <= 1'b0;           // wait for the next read
              rd_addr_q <= rd_addr_q - 1'b1;
              left_q    <= left_q - 1'b1;
              if (left_q == 16'd1) begin
                state_q <= ST_IDLE;
              end
            end else begin
              rd_vld_q <= 1'b1;
            end
          end
          default: ;                       // idle waits for arm
        endcase
      end
    end
  end

  assign we_o        = we;
  assign addr_o      = (state_q == ST_READ) ? rd_addr_q : wr_ptr_q;
  assign tx_o.stb    = tx_stb;
  assign tx_o.data   = mem_i;
  assign busy_o      = (state_q == ST_READ);

endmodule

`default_nettype wire

// ==== hw/la_trigger.sv ====
/*
 * la_trigger
 * four parallel trigger stages, each with mask, value and start bit.
 * once armed, the first strobed sample that matches any started
 * stage raises run, which holds until the next arm or reset
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_trigger (
  input  logic               clk_i,
  input  logic               reset_i,
  input  la_pkg::la_ctrl_s   ctrl_i,
  input  la_pkg::la_cmd_u    cmd_i,
  input  la_pkg::la_sample_s smpl_i,
  output logic               run_o         // triggered
);

  logic                  rst;
  logic [`LA_WIDTH-1:0]  mask_q [`LA_STAGES];
  logic [`LA_WIDTH-1:0]  val_q  [`LA_STAGES];
  logic [`LA_STAGES-1:0] start_q;
  logic [`LA_STAGES-1:0] hit;              // per stage match
  logic                  armed_q;
  logic                  run_q;

  assign rst = reset_i | ctrl_i.soft_rst;

  always_comb begin
    for (int n = 0; n < `LA_STAGES; n++) begin
      hit[n] = start_q[n] && ((smpl_i.data & mask_q[n]) == val_q[n]);
    end
  end

  // stage words, only looked at through start_q
  always_ff @(posedge clk_i) begin
    if (ctrl_i.set_mask) begin
      mask_q[ctrl_i.stg] <= cmd_i.raw;
    end
    if (ctrl_i.set_val) begin
      val_q[ctrl_i.stg] <= cmd_i.raw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      start_q <= '0;
      armed_q <= 1'b0;
      run_q   <= 1'b0;
    end else begin
      if (ctrl_i.set_cfg) begin
        start_q[ctrl_i.stg] <= cmd_i.trig_cfg.start;
      end
      if (ctrl_i.arm) begin
        armed_q <= 1'b1;
        run_q   <= 1'b0;                   // new capture
      end else if (armed_q && smpl_i.stb && (|hit)) begin
        armed_q <= 1'b0;                   // only the first match counts
        run_q   <= 1'b1;
      end
    end
  end

  assign run_o = run_q;

endmodule

`default_nettype wire

// ==== hw/la_sampler.sv ====
/*
 * la_sampler
 * programmable clock divider for the input bus. every div+1 cycles
 * the input is registered and marked with a one-cycle strobe
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_sampler (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  la_pkg::la_ctrl_s     ctrl_i,
  input  la_pkg::la_cmd_u      cmd_i,
  input  logic [`LA_WIDTH-1:0] data_i,    // bus under observation
  output la_pkg::la_sample_s   smpl_o
);

  logic                 rst;
  logic                 tick;              // divider wrapped
  logic [`LA_DIV_W-1:0] div_q;
  logic [`LA_DIV_W-1:0] cnt_q;
  logic                 stb_q;
  logic [`LA_WIDTH-1:0] data_q;

  assign rst  = reset_i | ctrl_i.soft_rst;
  assign tick = (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      div_q <= '0;                         // full rate after reset
      cnt_q <= '0;
      stb_q <= 1'b0;
    end else if (ctrl_i.set_div) begin
      div_q <= cmd_i.raw[`LA_DIV_W-1:0];
      cnt_q <= cmd_i.raw[`LA_DIV_W-1:0];   // restart count with new rate
      stb_q <= 1'b0;
    end else if (tick) begin
      cnt_q <= div_q;
      stb_q <= 1'b1;
    end else begin
      cnt_q <= cnt_q - 1'b1;
      stb_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tick) begin
      data_q <= data_i;                    // pairs with stb_q
    end
  end

  assign smpl_o.stb  = stb_q;
  assign smpl_o.data = data_q;

endmodule

`default_nettype wire

// ==== hw/la_cmd_decode.sv ====
/*
 * la_cmd_decode
 * turns each exec strobe into one-cycle control pulses, registered,
 * plus the stage index of the trigger opcode family. the command
 * word is held alongside so it is valid with the pulses
 */
`default_nettype none
`timescale 1ns/1ns

`include "la_macros.svh"

module la_cmd_decode (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 exec_i,     // one cycle, opc and cmd valid
  input  la_pkg::la_opcode_e   opc_i,
  input  logic [`LA_WIDTH-1:0] cmd_i,
  output la_pkg::la_ctrl_s     ctrl_o,     // pulses, one cycle after exec
  output la_pkg::la_cmd_u      cmd_o
);

  la_pkg::la_ctrl_s   ctrl_d;
  la_pkg::la_opcode_e opc_base;            // opcode with stage bits cleared

  always_comb begin
    ctrl_d   = '0;
    opc_base = la_pkg::la_opcode_e'({opc_i[7:4], 2'b00, opc_i[1:0]});
    if (exec_i) begin
      case (opc_i)
        la_pkg::OPC_RESET: ctrl_d.soft_rst = 1'b1;
        la_pkg::OPC_ARM:   ctrl_d.arm      = 1'b1;
        la_pkg::OPC_ID:    ctrl_d.id_req   = 1'b1;
        la_pkg::OPC_XON:   ctrl_d.xon      = 1'b1;
        la_pkg::OPC_XOFF:  ctrl_d.xoff     = 1'b1;
        la_pkg::OPC_DIV:   ctrl_d.set_div  = 1'b1;
        la_pkg::OPC_CNT:   ctrl_d.set_cnt  = 1'b1;
        default: ;                         // unknown, ignored
      endcase
      // trigger family C0..CE, stage in bits 3:2
      if (opc_i[7:4] == 4'hC) begin
        ctrl_d.stg = opc_i[3:2];
        case (opc_base)
          la_pkg::OPC_MASK0: ctrl_d.set_mask = 1'b1;
          la_pkg::OPC_VAL0:  ctrl_d.set_val  = 1'b1;
          la_pkg::OPC_CFG0:  ctrl_d.set_cfg  = 1'b1;
          default: ;                       // xx3, reserved
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_d;                    // all zero when no exec
    end
  end

  // command word follows the strobe, no reset needed
  always_ff @(posedge clk_i) begin
    if (exec_i) begin
      cmd_o.raw <= cmd_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/la_pkg.sv ====
/*
 * la_pkg
 * opcodes, the decoded views of the command word and the
 * structs that carry control pulses, samples and transmit words
 */
`default_nettype none

`include "la_macros.svh"

package la_pkg;

  // host opcodes, stage n adds 4*n to the C0..C2 family
  typedef enum logic [7:0] {
    OPC_RESET = 8'h00,
    OPC_ARM   = 8'h01,
    OPC_ID    = 8'h02,
    OPC_XON   = 8'h11,
    OPC_XOFF  = 8'h13,
    OPC_DIV   = 8'h80,
    OPC_CNT   = 8'h81,
    OPC_MASK0 = 8'hC0,              // trigger mask, stage 0
    OPC_VAL0  = 8'hC1,              // trigger value, stage 0
    OPC_CFG0  = 8'hC2               // trigger config, stage 0
  } la_opcode_e;

  typedef struct packed {
    logic [3:0]  rsvd_hi;
    logic        start;             // stage takes part in the match
    logic [1:0]  stage;
    logic [24:0] rsvd_lo;
  } la_trig_cfg_s;

  typedef struct packed {
    logic [15:0] read_cnt;          // words sent back
    logic [15:0] delay_cnt;         // samples written after trigger
  } la_cnt_s;

  // one command word, read as mask/value, trigger config or counts
  typedef union packed {
    logic [`LA_WIDTH-1:0] raw;
    la_trig_cfg_s         trig_cfg;
    la_cnt_s              cnt;
  } la_cmd_u;

  typedef struct packed {
    logic       soft_rst;
    logic       arm;
    logic       id_req;
    logic       xon;
    logic       xoff;
    logic       set_mask;
    logic       set_val;
    logic       set_cfg;
    logic       set_div;
    logic       set_cnt;
    logic [1:0] stg;                // stage index for mask/val/cfg
  } la_ctrl_s;

  typedef struct packed {
    logic                 stb;
    logic [`LA_WIDTH-1:0] data;
  } la_sample_s;

  typedef struct packed {
    logic                 stb;
    logic [`LA_WIDTH-1:0] data;
  } la_tx_s;

endpackage

`default_nettype wire

// ==== include/la_macros.svh ====
/*
 * la macros
 * sizes shared by the logic-analyzer core and its testbench:
 * sample width, memory address width, trigger stage count,
 * divider width and the fixed ID reply word
 */
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

`define LA_WIDTH    32              // sample and command word
`define LA_ADDR_W   5               // 32 words of sample memory
`define LA_STAGES   4               // parallel trigger stages
`define LA_DIV_W    24              // sample clock divider

// ascii "1ALS", first character in the top byte
`define LA_ID_WORD  32'h31414c53

`endif
